/* design/spi_frame_pkg.sv */
/*
 * SPI framing definitions shared by the deserializer, serializer and top
 * Bytes travel most significant bit first, one bit per rising clock edge
 * The bit index counts down, so index 7 is the first bit of a byte
 * Byte width is fixed at eight and the index type relies on that
 */

package spi_frame_pkg;

	// ****************************************
	// Byte framing
	// ****************************************

	// Bits per transferred byte
	localparam int byte_bits = 8;

	// One byte of payload, bit 7 goes out first
	typedef logic [byte_bits-1:0] byte_t;

	// Position inside the current byte, wraps from 0 back to 7
	typedef logic [$clog2(byte_bits)-1:0] bit_index_t;

	// MSB first order means the count starts high and ends at zero
	localparam bit_index_t first_bit = bit_index_t'(byte_bits - 1);
	localparam bit_index_t last_bit  = bit_index_t'(0);

endpackage

/* design/mailbox_pkg.sv */
/*
 * Mailbox store definitions
 * Slot count must stay a power of two so that a pointer wraps by overflow
 * There is no separate full or empty tracking, the pointers simply roll over
 */

package mailbox_pkg;

	// ****************************************
	// Store geometry
	// ****************************************

	// Number of byte slots in the store
	localparam int slot_count = 8;

	// Slot pointer, three bits for eight slots
	// Incrementing past the last slot lands back on slot 0
	typedef logic [$clog2(slot_count)-1:0] slot_ptr_t;

endpackage

/* design/spi_rx_deserializer.sv */
/*
 * Receive side of the SPI mailbox
 * din is sampled on every rising edge while csn is low, MSB first
 * The completed byte is offered combinationally during its last bit
 * A byte cut short by csn high is dropped, the bit count restarts at 7
 */

`timescale 1ns/10ps

module spi_rx_deserializer (
	input  logic                      rvx_signal_06,
	input  logic                      csn,
	input  logic                      din,
	output spi_frame_pkg::bit_index_t bit_index,
	output spi_frame_pkg::byte_t      rx_byte,
	output logic                      rx_done
);

	import spi_frame_pkg::*;

	// Seven earlier bits of the current byte
	// The eighth bit is still on din when the byte completes
	logic [byte_bits-2:0] rx_shift;

	// ****************************************
	// Bit counter
	// ****************************************

	// Counts down once per edge and wraps from 0 to 7 by overflow
	// csn high puts the framing back at the first bit
	always_ff @(posedge rvx_signal_06 or posedge csn)
	begin
		if (csn)
		begin
			bit_index <= first_bit;
		end
		else
		begin
			bit_index <= bit_index - 1'b1;
		end
	end

	// ****************************************
	// Shift register
	// ****************************************

	// Payload only, no reset
	// Stale bits from an aborted byte get pushed out by the next byte
	always_ff @(posedge rvx_signal_06)
	begin
		rx_shift <= {rx_shift[byte_bits-3:0], din};
	end

	// Full byte including the bit being sampled right now
	// Lets the store write on the same edge as the final bit
	assign rx_byte = {rx_shift, din};

	// High for the whole of the last bit of a byte
	assign rx_done = (bit_index == last_bit);

endmodule

/* design/spi_tx_serializer.sv */
/*
 * Transmit side of the SPI mailbox
 * A new byte is loaded on the first edge of every byte, MSB first on dout
 * dout changes right after the rising edge, the host samples it falling
 * dout is a plain output, any tristate enable belongs in the pad
 */

`timescale 1ns/10ps

module spi_tx_serializer (
	input  logic                      rvx_signal_06,
	input  logic                      csn,
	input  spi_frame_pkg::bit_index_t bit_index,
	input  spi_frame_pkg::byte_t      tx_byte,
	output logic                      tx_take,
	output logic                      dout
);

	import spi_frame_pkg::*;

	// Outgoing byte, top bit drives dout
	byte_t tx_shift;

	// ****************************************
	// Byte start
	// ****************************************

	// Byte start is seen from the shared bit index
	// Also tells the store to step its read pointer
	assign tx_take = (bit_index == first_bit);

	// ****************************************
	// Shift register
	// ****************************************

	// Reset so that dout idles low outside a transaction
	always_ff @(posedge rvx_signal_06 or posedge csn)
	begin
		if (csn)
		begin
			tx_shift <= '0;
		end
		else if (tx_take)
		begin
			// Slot under the read pointer, bit 7 shows after this edge
			tx_shift <= tx_byte;
		end
		else
		begin
			// Next lower bit, zeros fill from the bottom
			tx_shift <= {tx_shift[byte_bits-2:0], 1'b0};
		end
	end

	assign dout = tx_shift[byte_bits-1];

endmodule

/* design/mailbox_store.sv */
/*
 * Eight-slot byte store between the SPI receive and transmit paths
 * Slot contents have no reset and survive across transactions
 * csn high resets only the two pointers, so each transaction starts at slot 0
 * Write and read pointers move independently and wrap at eight
 */

`timescale 1ns/10ps

module mailbox_store (
	input  logic                 rvx_signal_06,
	input  logic                 csn,
	input  spi_frame_pkg::byte_t rx_byte,
	input  logic                 rx_done,
	input  logic                 tx_take,
	output spi_frame_pkg::byte_t tx_byte
);

	import spi_frame_pkg::*;
	import mailbox_pkg::*;

	// Byte slots, payload only
	byte_t slots [slot_count];

	// Next slot to be written by the receive side
	slot_ptr_t wr_ptr;

	// Next slot to be loaded by the transmit side
	slot_ptr_t rd_ptr;

	// ****************************************
	// Write path
	// ****************************************

	// Completed byte lands on the edge of its last bit
	always_ff @(posedge rvx_signal_06)
	begin
		if (rx_done)
		begin
			slots[wr_ptr] <= rx_byte;
		end
	end

	// Write pointer steps after every full byte
	always_ff @(posedge rvx_signal_06 or posedge csn)
	begin
		if (csn)
		begin
			wr_ptr <= '0;
		end
		else if (rx_done)
		begin
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	// ****************************************
	// Read path
	// ****************************************

	// Read pointer steps as the serializer takes a byte
	// It runs one byte ahead of the write pointer within a transaction
	always_ff @(posedge rvx_signal_06 or posedge csn)
	begin
		if (csn)
		begin
			rd_ptr <= '0;
		end
		else if (tx_take)
		begin
			rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// Slot under the read pointer
	// After eight bytes this returns what the same transaction wrote
	assign tx_byte = slots[rd_ptr];

endmodule

/* design/spi_mailbox_top.sv */
/*
 * SPI mailbox top level
 * Clock is assumed already adjusted for SPI mode 0, no CPOL or CPHA select
 * A written byte comes back out eight bytes later, counted from slot 0
 * No mode register and no interrupt, the host owns the clock
 */

`timescale 1ns/10ps

module spi_mailbox_top (
	input  logic rvx_signal_06,
	input  logic csn,
	input  logic din,
	output logic dout
);

	import spi_frame_pkg::*;

	// Shared framing position, also marks the transmit byte start
	bit_index_t bit_index;

	// Receive side into the store
	byte_t rx_byte;
	logic  rx_done;

	// Store out to the transmit side
	byte_t tx_byte;
	logic  tx_take;

	// ****************************************
	// Receive path
	// ****************************************

	spi_rx_deserializer u_rx (
		.rvx_signal_06 (rvx_signal_06),
		.csn           (csn),
		.din           (din),
		.bit_index     (bit_index),
		.rx_byte       (rx_byte),
		.rx_done       (rx_done)
	);

	// ****************************************
	// Transmit path
	// ****************************************

	spi_tx_serializer u_tx (
		.rvx_signal_06 (rvx_signal_06),
		.csn           (csn),
		.bit_index     (bit_index),
		.tx_byte       (tx_byte),
		.tx_take       (tx_take),
		.dout          (dout)
	);

	// ****************************************
	// Byte store
	// ****************************************

	mailbox_store u_store (
		.rvx_signal_06 (rvx_signal_06),
		.csn           (csn),
		.rx_byte       (rx_byte),
		.rx_done       (rx_done),
		.tx_take       (tx_take),
		.tx_byte       (tx_byte)
	);

endmodule

/* bench/spi_mailbox_asserts.sv */
/*
 * Concurrent checks on the mailbox store, bound into every mailbox_store
 * Pointer gap is checked only while csn is low
 * Every failure also bumps fail_count
 */

`timescale 1ns/10ps

module spi_mailbox_asserts (
	input logic                   rvx_signal_06,
	input logic                   csn,
	input logic                   rx_done,
	input logic                   tx_take,
	input mailbox_pkg::slot_ptr_t wr_ptr,
	input mailbox_pkg::slot_ptr_t rd_ptr
);

	import mailbox_pkg::*;

	// Read pointer lead over the write pointer, wraps with the pointers
	slot_ptr_t ptr_gap;

	// Number of assertion failures so far, read by the testbench at the end
	int fail_count = 0;

	assign ptr_gap = rd_ptr - wr_ptr;

	// ****************************************
	// Strobes and pointers
	// ****************************************

	// First bit and last bit of a byte never coincide
	strobe_exclusive: assert property (@(posedge rvx_signal_06)
		!(rx_done && tx_take))
		else
		begin
			fail_count++;
			$error("rx_done and tx_take are high in the same cycle");
		end

	// Read side loads a byte before the write side completes it
	ptr_gap_bound: assert property (@(posedge rvx_signal_06) disable iff (csn)
		ptr_gap <= slot_ptr_t'(1))
		else
		begin
			fail_count++;
			$error("read pointer is not 0 or 1 ahead of the write pointer");
		end

	// Every transaction starts at slot 0
	ptr_start: assert property (@(posedge rvx_signal_06)
		$fell(csn) |-> (wr_ptr == '0 && rd_ptr == '0))
		else
		begin
			fail_count++;
			$error("pointers are not at slot 0 at the start of a transaction");
		end

endmodule

bind mailbox_store spi_mailbox_asserts u_asserts (
	.rvx_signal_06 (rvx_signal_06),
	.csn           (csn),
	.rx_done       (rx_done),
	.tx_take       (tx_take),
	.wr_ptr        (wr_ptr),
	.rd_ptr        (rd_ptr)
);

/* bench/tb_spi_mailbox.sv */
/*
 * Testbench for the SPI mailbox top level
 * dout is compared on falling edges against a shadow model of the store
 * Slots never written since time zero are unknown and their bits are skipped
 * The last bit of a transaction is not visible, csn resets dout right after it
 */

`timescale 1ns/10ps

module tb_spi_mailbox;

	import spi_frame_pkg::*;
	import mailbox_pkg::*;

	// Bits driven by all tests, used to size the watchdog
	// Fill 128, wrap 96, abort 29 + 64, short 72 + 64, random at most 20 x 16 x 8
	localparam int total_bits  = 128 + 96 + 93 + 136 + 2560;
	localparam int watchdog_ns = total_bits * 20 * 2;

	logic rvx_signal_06;
	logic csn;
	logic din;
	logic dout;

	// Host side bytes of the current transaction
	byte_t host_data [0:15];

	// Shadow store and the expected outgoing bytes of the current transaction
	byte_t shadow [slot_count];
	logic  shadow_known [slot_count];
	byte_t exp_byte [0:15];
	logic  exp_known [0:15];
	int    cur_bits;

	logic [31:0] rng_state = 32'h4e77;
	int edge_cnt;
	int check_count;
	int error_count;
	int base_checks;
	int base_errors;
	int cmp_byte;
	logic cmp_bit;

	spi_mailbox_top dut (
		.rvx_signal_06 (rvx_signal_06),
		.csn           (csn),
		.din           (din),
		.dout          (dout)
	);

	// 20 ns clock period
	initial rvx_signal_06 = 1'b0;
	always #10 rvx_signal_06 = ~rvx_signal_06;

	// ****************************************
	// Reference model
	// ****************************************

	function automatic logic [31:0] lcg_next();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	// Byte currently held in one slot of the store
	function automatic byte_t slot_value(input int slot);
		return shadow[slot];
	endfunction

	// Bit on dout after counted edge n, MSB of byte k shows after edge 8k+1
	function automatic logic expected_dout(input int n);
		return exp_byte[(n - 1) / 8][7 - ((n - 1) % 8)];
	endfunction

	// Walk the bytes in order, a read of slot s sees writes of earlier bytes
	// Only complete bytes are written, a partial one is dropped
	task automatic model_txn(input int nbits);
		int k;
		begin
			for (k = 0; k < (nbits + 7) / 8; k++)
			begin
				exp_byte[k]  = slot_value(k % slot_count);
				exp_known[k] = shadow_known[k % slot_count];
				if (k < nbits / 8)
				begin
					shadow[k % slot_count]       = host_data[k];
					shadow_known[k % slot_count] = 1'b1;
				end
			end
			cur_bits = nbits;
		end
	endtask

	// ****************************************
	// Stimulus
	// ****************************************

	task automatic fill_random(input int nbytes);
		int k;
		begin
			for (k = 0; k < nbytes; k++)
			begin
				host_data[k] = byte_t'(lcg_next() >> 16);
			end
		end
	endtask

	// csn drops on an uncounted edge, the final edge still samples csn low
	task automatic run_txn(input int nbits);
		int i;
		begin
			model_txn(nbits);
			@(posedge rvx_signal_06);
			csn <= 1'b0;
			din <= host_data[0][7];
			for (i = 1; i < nbits; i++)
			begin
				@(posedge rvx_signal_06);
				din <= host_data[i / 8][7 - (i % 8)];
			end
			@(posedge rvx_signal_06);
			csn <= 1'b1;
			din <= 1'b0;
			repeat (3) @(posedge rvx_signal_06);
		end
	endtask

	// One line per test, a test that compared nothing also counts as an error
	task automatic report_test(input string name);
		begin
			if (check_count == base_checks)
			begin
				error_count++;
				$display("%s: no dout bits were compared", name);
			end
			$display("%s: %0d checks, %0d errors", name,
				check_count - base_checks, error_count - base_errors);
			base_checks = check_count;
			base_errors = error_count;
		end
	endtask

	// ****************************************
	// Compare process
	// ****************************************

	// First falling edge with csn low follows the uncounted edge
	always @(negedge rvx_signal_06)
	begin
		if (csn)
		begin
			edge_cnt = 0;
		end
		else
		begin
			if (edge_cnt >= 1 && edge_cnt <= cur_bits)
			begin
				cmp_byte = (edge_cnt - 1) / 8;
				if (exp_known[cmp_byte])
				begin
					cmp_bit = expected_dout(edge_cnt);
					check_count++;
					if (dout !== cmp_bit)
					begin
						error_count++;
						$display("Fail at %0t ns: dout expected %b got %b (byte %0d)",
							$time, cmp_bit, dout, cmp_byte);
					end
				end
			end
			edge_cnt++;
		end
	end

	// ****************************************
	// Test sequence
	// ****************************************

	initial
	begin
		int t;
		int k;
		csn <= 1'b1;
		din <= 1'b0;
		for (k = 0; k < slot_count; k++)
		begin
			shadow_known[k] = 1'b0;
		end
		repeat (8) @(posedge rvx_signal_06);
		check_count++;
		if (dout !== 1'b0)
		begin
			error_count++;
			$display("Fail at %0t ns: dout expected 0 got %b after reset", $time, dout);
		end
		// A fills the store unchecked, B reads A back
		fill_random(8);
		run_txn(64);
		fill_random(8);
		run_txn(64);
		report_test("Test 1 fill then read back");
		// Bytes 8 to 11 come from slots this transaction wrote
		fill_random(12);
		run_txn(96);
		report_test("Test 2 wrap within a transaction");
		// Abort after 5 bits of byte 3, slot 3 keeps its value
		fill_random(4);
		run_txn(29);
		fill_random(8);
		run_txn(64);
		report_test("Test 3 abort mid-byte");
		fill_random(1);
		run_txn(8);
		fill_random(3);
		run_txn(24);
		fill_random(2);
		run_txn(16);
		fill_random(1);
		run_txn(8);
		fill_random(2);
		run_txn(16);
		fill_random(8);
		run_txn(64);
		report_test("Test 4 short transactions");
		for (t = 0; t < 20; t++)
		begin
			k = 1 + ((lcg_next() >> 16) % 16);
			fill_random(k);
			run_txn(k * 8);
		end
		report_test("Test 5 random streams");
		// Failures of the store checker count as errors too
		if (dut.u_store.u_asserts.fail_count != 0)
		begin
			error_count += dut.u_store.u_asserts.fail_count;
			$display("Assertions in mailbox_store failed %0d times",
				dut.u_store.u_asserts.fail_count);
		end
		$display("Totals: %0d checks, %0d errors", check_count, error_count);
		if (error_count == 0)
		begin
			$display("All checks passed");
		end
		else
		begin
			$display("Checks failed");
		end
		$finish;
	end

	// Watchdog, twice the time of every bit in all tests
	initial
	begin
		#(watchdog_ns);
		$display("Timeout: the tests did not finish in %0d ns", watchdog_ns);
		$display("Checks failed");
		$finish;
	end

endmodule

/* sim.f */
design/spi_frame_pkg.sv
design/mailbox_pkg.sv
design/spi_rx_deserializer.sv
design/spi_tx_serializer.sv
design/mailbox_store.sv
design/spi_mailbox_top.sv
bench/spi_mailbox_asserts.sv
bench/tb_spi_mailbox.sv

/* Bender.yml */
package:
  name: spi_mailbox

sources:
  # Packages first, then leaf modules, then the top level
  - design/spi_frame_pkg.sv
  - design/mailbox_pkg.sv
  - design/spi_rx_deserializer.sv
  - design/spi_tx_serializer.sv
  - design/mailbox_store.sv
  - design/spi_mailbox_top.sv

  - target: simulation
    files:
      - bench/spi_mailbox_asserts.sv
      - bench/tb_spi_mailbox.sv
